// File: hw/pkt_fifo_pkg.sv
`default_nettype none

// shared stream types for the packet FIFO
package pkt_fifo_pkg;

   // ------------------------------------------------------------------
   // lane constants
   // ------------------------------------------------------------------
   localparam int DATA_BYTES = 8;    // byte lanes per beat
   localparam int TID_WID    = 4;    // stream id width
   localparam int TDEST_WID  = 4;    // routing destination width
   localparam int TUSER_WID  = 8;    // sideband width

   typedef logic [TID_WID-1:0]   tid_t;
   typedef logic [TDEST_WID-1:0] tdest_t;
   typedef logic [TUSER_WID-1:0] tuser_t;

   // ------------------------------------------------------------------
   // one stream beat, also the memory word
   // ------------------------------------------------------------------
   // field order puts tlast on top so it sits in the msb of the word
   typedef struct packed {
      logic                       tlast;   // end of packet
      tid_t                       tid;
      tdest_t                     tdest;
      tuser_t                     tuser;
      logic [DATA_BYTES-1:0]      tkeep;   // one bit per byte lane
      logic [DATA_BYTES-1:0][7:0] tdata;   // lane 0 in the low byte
   } axis_beat_t;

endpackage

`default_nettype wire

// File: hw/pkt_ingress_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// ingress side of the packet FIFO
// accepts beats, keeps the write pointer and the commit pointer
module pkt_ingress_ctrl #(
   parameter int ADDR_WID = 4                         // depth is 2**ADDR_WID beats
) (
   input  wire logic                     axi4s_in,    // stream clock
   input  wire logic                     reset,       // sync, active high
   input  wire logic                     in_valid,
   input  wire pkt_fifo_pkg::axis_beat_t in_beat,
   input  wire logic [ADDR_WID:0]        rd_ptr,      // egress read pointer
   output logic                          in_ready,
   output logic                          wr_req,      // one strobe per accepted beat
   output logic [ADDR_WID:0]             wr_ptr,      // next slot to write, msb is wrap
   output pkt_fifo_pkg::axis_beat_t      wr_beat,
   output logic [ADDR_WID:0]             commit_ptr   // end of last whole packet
);

   logic              full;        // every slot holds a beat not yet read
   logic              wrap_diff;   // pointers are on different laps
   logic              addr_same;   // pointers address the same slot
   logic [ADDR_WID:0] wr_ptr_inc;

   // ------------------------------------------------------------------
   // full test and handshake
   // ------------------------------------------------------------------
   assign wrap_diff = wr_ptr[ADDR_WID] != rd_ptr[ADDR_WID];
   assign addr_same = wr_ptr[ADDR_WID-1:0] == rd_ptr[ADDR_WID-1:0];
   assign full      = wrap_diff && addr_same;   // same slot, one lap ahead

   // rd_ptr only moves forward, so a slot freed this cycle shows up next cycle
   assign in_ready  = !full;
   assign wr_req    = in_valid && in_ready;     // beat transfers at this edge

   // memory takes the beat in the same cycle it is accepted
   assign wr_beat   = in_beat;

   assign wr_ptr_inc = wr_ptr + 1'b1;

   // ------------------------------------------------------------------
   // write and commit pointers
   // ------------------------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
      end else if (wr_req) begin
         wr_ptr <= wr_ptr_inc;                  // one slot per beat
         // the packet becomes readable only once its tlast is stored
         if (in_beat.tlast) begin
            commit_ptr <= wr_ptr_inc;           // point just past the last beat
         end
      end
   end

   // partial packets sit between commit_ptr and wr_ptr, hidden from egress

endmodule

`default_nettype wire

// File: hw/pkt_buffer_mem.sv
`timescale 1ns/100ps
`default_nettype none

// pipelined packet buffer
// dual port memory, commit pointer delay and read valid pipeline
module pkt_buffer_mem #(
   parameter int ADDR_WID  = 4,                       // depth is 2**ADDR_WID beats
   parameter int WR_STAGES = 1,                       // commit pointer delay
   parameter int RD_STAGES = 1                        // output regs after memory read reg
) (
   input  wire logic                     axi4s_in,    // stream clock
   input  wire logic                     reset,       // sync, active high
   input  wire logic                     wr_req,
   input  wire logic [ADDR_WID:0]        wr_ptr,
   input  wire pkt_fifo_pkg::axis_beat_t wr_beat,
   input  wire logic [ADDR_WID:0]        commit_ptr,
   input  wire logic                     rd_req,
   input  wire logic [ADDR_WID:0]        rd_ptr,
   output logic [ADDR_WID:0]             commit_ptr_p, // commit_ptr after WR_STAGES
   output logic                          out_valid,
   output pkt_fifo_pkg::axis_beat_t      out_beat
);

   import pkt_fifo_pkg::*;

   localparam int DEPTH = 2**ADDR_WID;

   axis_beat_t           mem [DEPTH];      // plain inferred array
   axis_beat_t           rd_data;          // memory read register
   logic [RD_STAGES:0]   rd_req_p;         // one extra stage for the read register

   // ------------------------------------------------------------------
   // commit pointer pipeline
   // ------------------------------------------------------------------
   generate
      if (WR_STAGES > 0) begin : g_commit_pipe
         logic [ADDR_WID:0] commit_pipe [WR_STAGES];

         always_ff @(posedge axi4s_in) begin
            if (reset) begin
               for (int i = 0; i < WR_STAGES; i++) begin
                  commit_pipe[i] <= '0;
               end
            end else begin
               commit_pipe[0] <= commit_ptr;
               for (int i = 1; i < WR_STAGES; i++) begin
                  commit_pipe[i] <= commit_pipe[i-1];
               end
            end
         end

         assign commit_ptr_p = commit_pipe[WR_STAGES-1];
      end else begin : g_commit_direct
         assign commit_ptr_p = commit_ptr;   // beat is already in memory
      end
   endgenerate

   // ------------------------------------------------------------------
   // memory, low ADDR_WID bits of each pointer address it
   // ------------------------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (wr_req) begin
         mem[wr_ptr[ADDR_WID-1:0]] <= wr_beat;
      end
      if (rd_req) begin
         rd_data <= mem[rd_ptr[ADDR_WID-1:0]];   // read register holds between reads
      end
   end

   // output data registers
   generate
      if (RD_STAGES > 0) begin : g_rd_pipe
         axis_beat_t rd_data_p [RD_STAGES];

         always_ff @(posedge axi4s_in) begin
            rd_data_p[0] <= rd_data;
            for (int i = 1; i < RD_STAGES; i++) begin
               rd_data_p[i] <= rd_data_p[i-1];
            end
         end

         assign out_beat = rd_data_p[RD_STAGES-1];
      end else begin : g_rd_direct
         assign out_beat = rd_data;
      end
   endgenerate

   // ------------------------------------------------------------------
   // read request pipeline, lines up valid with the data
   // ------------------------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         rd_req_p <= '0;
      end else begin
         rd_req_p[0] <= rd_req;
         for (int i = 1; i <= RD_STAGES; i++) begin
            rd_req_p[i] <= rd_req_p[i-1];
         end
      end
   end

   assign out_valid = rd_req_p[RD_STAGES];   // no egress back-pressure

endmodule

`default_nettype wire

// File: hw/pkt_egress_sched.sv
`timescale 1ns/100ps
`default_nettype none

// egress scheduler
// reads out committed beats one per cycle
module pkt_egress_sched #(
   parameter int ADDR_WID = 4                      // depth is 2**ADDR_WID beats
) (
   input  wire logic                axi4s_in,      // stream clock
   input  wire logic                reset,         // sync, active high
   input  wire logic [ADDR_WID:0]   commit_ptr_p,  // delayed commit pointer
   output logic                     rd_req,        // read strobe, one per beat
   output logic [ADDR_WID:0]        rd_ptr         // slot of the current request
);

   logic [ADDR_WID:0] rd_ptr_nxt;   // pointer after this cycle
   logic              more;         // committed beats remain past rd_ptr_nxt

   // ------------------------------------------------------------------
   // next pointer and request decision
   // ------------------------------------------------------------------
   // a request in flight consumes the slot at rd_ptr
   assign rd_ptr_nxt = rd_req ? rd_ptr + 1'b1 : rd_ptr;

   // full wrap bit compare, so a lap ahead never reads as empty
   assign more = rd_ptr_nxt != commit_ptr_p;

   // ------------------------------------------------------------------
   // request and pointer registers
   // ------------------------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         rd_req <= 1'b0;
         rd_ptr <= '0;
      end else begin
         rd_ptr <= rd_ptr_nxt;   // advance with each request
         rd_req <= more;         // back to back while beats remain
      end
   end

   // packets committed back to back drain without a gap since
   // commit_ptr_p only grows and more stays high across the boundary

endmodule

`default_nettype wire

// File: hw/pkt_fifo_top.sv
`timescale 1ns/100ps
`default_nettype none

// store and forward packet FIFO
module pkt_fifo_top #(
   parameter int ADDR_WID  = 4,   // 16 beat buffer
   parameter int WR_STAGES = 1,   // commit delay in the buffer
   parameter int RD_STAGES = 1    // output regs after memory read reg
) (
   input  wire logic                     axi4s_in,   // stream clock
   input  wire logic                     reset,      // sync, active high
   input  wire logic                     in_valid,
   input  wire pkt_fifo_pkg::axis_beat_t in_beat,
   output logic                          in_ready,
   output logic                          out_valid,
   output pkt_fifo_pkg::axis_beat_t      out_beat
);

   import pkt_fifo_pkg::*;

   // ------------------------------------------------------------------
   // internal wiring
   // ------------------------------------------------------------------
   logic              wr_req;
   logic [ADDR_WID:0] wr_ptr;
   axis_beat_t        wr_beat;
   logic [ADDR_WID:0] commit_ptr;     // ingress side
   logic [ADDR_WID:0] commit_ptr_p;   // after the buffer write pipeline
   logic              rd_req;
   logic [ADDR_WID:0] rd_ptr;         // also feeds the full test

   pkt_ingress_ctrl #(
      .ADDR_WID (ADDR_WID)
   ) pkt_ingress_ctrl_i (
      .axi4s_in   (axi4s_in),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_beat    (in_beat),
      .rd_ptr     (rd_ptr),
      .in_ready   (in_ready),
      .wr_req     (wr_req),
      .wr_ptr     (wr_ptr),
      .wr_beat    (wr_beat),
      .commit_ptr (commit_ptr)
   );

   pkt_buffer_mem #(
      .ADDR_WID  (ADDR_WID),
      .WR_STAGES (WR_STAGES),
      .RD_STAGES (RD_STAGES)
   ) pkt_buffer_mem_i (
      .axi4s_in     (axi4s_in),
      .reset        (reset),
      .wr_req       (wr_req),
      .wr_ptr       (wr_ptr),
      .wr_beat      (wr_beat),
      .commit_ptr   (commit_ptr),
      .rd_req       (rd_req),
      .rd_ptr       (rd_ptr),
      .commit_ptr_p (commit_ptr_p),
      .out_valid    (out_valid),
      .out_beat     (out_beat)
   );

   pkt_egress_sched #(
      .ADDR_WID (ADDR_WID)
   ) pkt_egress_sched_i (
      .axi4s_in     (axi4s_in),
      .reset        (reset),
      .commit_ptr_p (commit_ptr_p),
      .rd_req       (rd_req),
      .rd_ptr       (rd_ptr)
   );

endmodule

`default_nettype wire

// File: tests/pkt_fifo_props.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_fifo_props #(
   parameter int ADDR_WID  = 4,
   parameter int RD_STAGES = 1
) (
   input wire logic                axi4s_in,
   input wire logic                reset,
   input wire logic                wr_req,
   input wire logic                rd_req,
   input wire logic                out_valid,
   input wire logic [ADDR_WID:0]   wr_ptr,
   input wire logic [ADDR_WID:0]   commit_ptr,
   input wire logic [ADDR_WID:0]   commit_ptr_p,
   input wire logic [ADDR_WID:0]   rd_ptr
);

   localparam logic [ADDR_WID:0] DEPTH = {1'b1, {ADDR_WID{1'b0}}};

   logic [ADDR_WID:0] fill;        // beats held, committed or not
   logic [ADDR_WID:0] commit_cnt;  // beats up to commit_ptr
   logic [ADDR_WID:0] ready_cnt;   // beats the scheduler may still read
   int                fail_count = 0;

   assign fill       = wr_ptr - rd_ptr;
   assign commit_cnt = commit_ptr - rd_ptr;
   assign ready_cnt  = commit_ptr_p - rd_ptr;

   // ------------------------------------------------------------------
   // pointer order rd <= commit_p <= commit <= wr, within one lap
   // ------------------------------------------------------------------
   a_fill_bound: assert property (@(posedge axi4s_in) disable iff (reset)
      fill <= DEPTH)
      else begin $error("write pointer lapped the read pointer"); fail_count++; end

   a_ptr_order: assert property (@(posedge axi4s_in) disable iff (reset)
      ready_cnt <= commit_cnt && commit_cnt <= fill)
      else begin $error("pointers out of order"); fail_count++; end

   // fixed read latency
   a_valid_lat: assert property (@(posedge axi4s_in) disable iff (reset)
      out_valid == $past(rd_req, RD_STAGES+1))
      else begin $error("out_valid does not match rd_req"); fail_count++; end

   a_no_full_wr: assert property (@(posedge axi4s_in) disable iff (reset)
      !(wr_req && fill == DEPTH))
      else begin $error("write into a full buffer"); fail_count++; end

endmodule

bind pkt_fifo_top pkt_fifo_props #(
   .ADDR_WID  (ADDR_WID),
   .RD_STAGES (RD_STAGES)
) pkt_fifo_props_i (
   .axi4s_in     (axi4s_in),
   .reset        (reset),
   .wr_req       (wr_req),
   .rd_req       (rd_req),
   .out_valid    (out_valid),
   .wr_ptr       (wr_ptr),
   .commit_ptr   (commit_ptr),
   .commit_ptr_p (commit_ptr_p),
   .rd_ptr       (rd_ptr)
);

`default_nettype wire

// File: tests/pkt_fifo_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_fifo_tb;

   import pkt_fifo_pkg::*;

   localparam int NUM_PKTS = 12;

   typedef logic [95:0] word_t;             // wide enough for a whole beat

   // one row per packet
   typedef struct packed {
      int                    len;           // beats, 1 to 16
      tid_t                  tid;
      tdest_t                tdest;
      tuser_t                tuser;
      logic [7:0]            base;          // first data byte
      logic [DATA_BYTES-1:0] last_keep;     // tkeep of the tlast beat
      logic                  burst;         // no idle cycles inside or after
   } pkt_row_t;

   pkt_row_t pkt_tab [NUM_PKTS] = '{
      '{ 1, 4'h1, 4'h2, 8'h10, 8'h00, 8'h0f, 1'b0},
      '{ 3, 4'h2, 4'h3, 8'h21, 8'h40, 8'hff, 1'b0},
      '{ 5, 4'h3, 4'h1, 8'h32, 8'h80, 8'h07, 1'b0},
      '{ 1, 4'h4, 4'h0, 8'h43, 8'hc0, 8'h01, 1'b0},
      '{ 8, 4'h5, 4'h7, 8'h54, 8'h11, 8'h3f, 1'b0},
      '{ 2, 4'h6, 4'h5, 8'h65, 8'h52, 8'hff, 1'b0},
      '{16, 4'h7, 4'h6, 8'h76, 8'h93, 8'h7f, 1'b1},   // fills all 16 slots
      '{ 4, 4'h8, 4'h4, 8'h87, 8'hd4, 8'h03, 1'b1},   // runs into the full buffer
      '{ 1, 4'h9, 4'h8, 8'h98, 8'h15, 8'hff, 1'b0},
      '{ 7, 4'ha, 4'h9, 8'ha9, 8'h56, 8'h1f, 1'b0},
      '{ 2, 4'hb, 4'ha, 8'hba, 8'h97, 8'h0f, 1'b0},
      '{ 6, 4'hc, 4'hb, 8'hcb, 8'hd8, 8'hff, 1'b0}
   };

   logic       axi4s_in;
   logic       reset;
   logic       in_valid;
   logic       in_ready;
   logic       out_valid;
   axis_beat_t in_beat;
   axis_beat_t out_beat;

   axis_beat_t exp_q [$];                   // accepted beats not yet seen at egress
   int         pkt_q [$];                   // packet number of each queued beat
   int         pkts_in  = 0;                // packets whose tlast has been accepted
   int         errors   = 0;
   int         checks   = 0;
   int         seed     = 39450;
   bit         in_pkt   = 1'b0;             // egress is inside a packet
   bit         saw_full = 1'b0;

   pkt_fifo_top pkt_fifo_top_i (
      .axi4s_in  (axi4s_in),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_beat  (out_beat)
   );

   initial axi4s_in = 1'b0;
   always #5 axi4s_in = ~axi4s_in;          // 10 ns period

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   task automatic check(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // beat idx of a table row, data bytes count up from base
   function automatic axis_beat_t make_beat(input pkt_row_t row, input int idx);
      axis_beat_t b;
      b.tlast = (idx == row.len - 1);
      b.tid   = row.tid;
      b.tdest = row.tdest;
      b.tuser = row.tuser;
      b.tkeep = b.tlast ? row.last_keep : '1;
      for (int i = 0; i < DATA_BYTES; i++) begin
         b.tdata[i] = row.base + 8'(idx * DATA_BYTES + i);
      end
      return b;
   endfunction

   // holds the beat until a rising edge with ready high, ends 1 ns after it
   task automatic send_beat(input axis_beat_t beat);
      bit taken;
      in_beat  = beat;
      in_valid = 1'b1;
      taken    = 1'b0;
      while (!taken) begin
         @(negedge axi4s_in);
         taken = in_ready;                  // ready is settled mid cycle
         @(posedge axi4s_in);
      end
      #1;
      in_valid = 1'b0;
   endtask

   // ------------------------------------------------------------------
   // egress scoreboard and ingress capture, mid cycle
   // ------------------------------------------------------------------
   always @(negedge axi4s_in) begin
      if (!reset) begin
         if (in_pkt) begin
            check(word_t'(out_valid), word_t'(1), "gap inside a packet");
         end
         if (out_valid) begin
            if (exp_q.size() == 0) begin
               check(word_t'(0), word_t'(1), "egress beat with nothing expected");
            end else begin
               check(word_t'(out_beat), word_t'(exp_q[0]), "egress beat");
               check(word_t'(pkt_q[0] < pkts_in), word_t'(1),
                     "beat left before its tlast was accepted");   // store and forward
               void'(exp_q.pop_front());
               void'(pkt_q.pop_front());
            end
         end
         in_pkt = out_valid && !out_beat.tlast;
         if (in_valid && !in_ready) saw_full = 1'b1;
         if (in_valid && in_ready) begin                // taken at the next edge
            exp_q.push_back(in_beat);
            pkt_q.push_back(pkts_in);
            if (in_beat.tlast) pkts_in++;
         end
      end
   end

   // ------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------
   initial begin
      int idle;
      in_valid = 1'b0;
      in_beat  = '0;
      reset    = 1'b1;
      repeat (3) @(posedge axi4s_in);
      #1;
      reset = 1'b0;
      @(negedge axi4s_in);
      check(word_t'(out_valid), word_t'(0), "out_valid after reset");
      check(word_t'(in_ready), word_t'(1), "in_ready after reset");
      @(posedge axi4s_in);
      #1;
      for (int p = 0; p < NUM_PKTS; p++) begin
         for (int b = 0; b < pkt_tab[p].len; b++) begin
            send_beat(make_beat(pkt_tab[p], b));
            if (!pkt_tab[p].burst) begin
               idle = $random(seed) & 3;   // idle even when ready is high
               if (idle > 0) begin
                  repeat (idle) @(posedge axi4s_in);
                  #1;
               end
            end
         end
      end
      while (exp_q.size() != 0) @(posedge axi4s_in);
      repeat (20) @(posedge axi4s_in);      // any stray beat shows up here
      check(word_t'(saw_full), word_t'(1), "in_ready never fell with the buffer full");
      errors += pkt_fifo_top_i.pkt_fifo_props_i.fail_count;
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // watchdog, 20 cycles per table beat plus margin
   initial begin
      int limit;
      limit = 0;
      for (int p = 0; p < NUM_PKTS; p++) limit += pkt_tab[p].len;
      limit = limit * 20 + 200;
      repeat (limit) @(posedge axi4s_in);
      $display("timeout: %0d beats still expected after %0d cycles", exp_q.size(), limit);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
hw/pkt_fifo_pkg.sv
hw/pkt_ingress_ctrl.sv
hw/pkt_buffer_mem.sv
hw/pkt_egress_sched.sv
hw/pkt_fifo_top.sv
tests/pkt_fifo_props.sv
tests/pkt_fifo_tb.sv

// File: Makefile
TOP = pkt_fifo_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
